// ==== Makefile ====
SIM = obj_dir/Vdram_ctrl_tb

all: run

$(SIM): dram_ctrl.f $(wildcard verilog/*.sv bench/*.sv)
	verilator --binary --timing --top-module dram_ctrl_tb -f dram_ctrl.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module dram_ctrl -f dram_ctrl.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// ==== bench/dram_ctrl_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dram_ctrl_tb;

    // about twice the cycles that all tests take together
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int ACCESS_LIMIT = 40;
    localparam int REF_PERIOD = int'(dram_timing_pkg::T_REFI) + int'(dram_timing_pkg::T_RFC);

    logic                    CLK;
    logic                    nRST;
    logic                    req_valid;
    dram_cmd_pkg::host_req_t req;
    logic                    ready;
    logic                    done;
    dram_cmd_pkg::dram_cmd_t cmd;
    logic                    rd_en;
    logic                    wr_en;

    int          error_count;
    int          cycle_no;
    int          watchdog = 0;
    int          idle_interval;
    int          last_ref;
    logic [15:0] lfsr;

    dram_ctrl dram_ctrl_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .req_valid (req_valid),
        .req       (req),
        .ready     (ready),
        .done      (done),
        .cmd       (cmd),
        .rd_en     (rd_en),
        .wr_en     (wr_en)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        watchdog <= watchdog + 1;
        if (watchdog >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d", error_count + 1);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[15]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic random_request(output dram_cmd_pkg::host_req_t r);
        logic [31:0] bits;
        take_bits(1, bits);
        r.write = bits[0];
        take_bits(int'(dram_cmd_pkg::BANK_W), bits);
        r.bank = bits[dram_cmd_pkg::BANK_W-1:0];
        take_bits(int'(dram_cmd_pkg::ROW_W), bits);
        r.row = bits[dram_cmd_pkg::ROW_W-1:0];
        take_bits(int'(dram_cmd_pkg::COL_W), bits);
        r.col = bits[dram_cmd_pkg::COL_W-1:0];
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h at cycle %0d",
                     name, actual, expected, cycle_no);
            error_count++;
        end
    endtask

    task automatic note_error(input string what);
        $display("ERROR: %s at cycle %0d", what, cycle_no);
        error_count++;
    endtask

    // outputs are sampled and inputs driven on the falling edge
    task automatic tick();
        @(negedge CLK);
        cycle_no++;
    endtask

    task automatic check_quiet_outputs();
        check_value("cmd.op", 32'(cmd.op), 32'(dram_cmd_pkg::NOP));
        check_value("rd_en", 32'(rd_en), 32'(1'b0));
        check_value("wr_en", 32'(wr_en), 32'(1'b0));
        check_value("done", 32'(done), 32'(1'b0));
        check_value("ready", 32'(ready), 32'(1'b1));
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < ACCESS_LIMIT) begin
            tick();
            n++;
        end
        if (!ready) begin
            note_error("ready stayed low, no request could be issued");
        end
    endtask

    // one access from strobe through PRE and tRP back to IDLE
    task automatic run_access(input dram_cmd_pkg::host_req_t r, input logic check_ready,
                              output int pre_cycle);
        dram_cmd_pkg::dram_op_t cas_op;
        int   lat;
        int   k;
        int   start;
        int   t_act;
        int   t_cas;
        int   t_pre;
        int   t_done;
        int   en_first;
        int   en_last;
        int   en_count;
        int   wrong_en;
        int   done_count;
        int   ready_busy;
        logic finished;
        logic en;
        logic op_ok;

        cas_op = r.write ? dram_cmd_pkg::WR : dram_cmd_pkg::RD;
        lat = r.write ? int'(dram_timing_pkg::T_WL) : int'(dram_timing_pkg::T_RL);
        t_act = -1;
        t_cas = -1;
        t_pre = -1;
        t_done = -1;
        en_first = -1;
        en_last = -1;
        en_count = 0;
        wrong_en = 0;
        done_count = 0;
        ready_busy = 0;
        finished = 1'b0;
        pre_cycle = -1;
        k = 0;

        wait_ready();
        start = cycle_no;
        req = r;
        req_valid = 1'b1;
        while (!finished && k < ACCESS_LIMIT) begin
            tick();
            k++;
            req_valid = 1'b0;
            if (cmd.op != dram_cmd_pkg::NOP) begin
                op_ok = 1'b1;
                if (cmd.op == dram_cmd_pkg::ACT && t_act < 0) begin
                    t_act = k;
                end else if (cmd.op == cas_op && t_act >= 0 && t_cas < 0) begin
                    t_cas = k;
                end else if (cmd.op == dram_cmd_pkg::PRE && t_cas >= 0 && t_pre < 0) begin
                    t_pre = k;
                end else begin
                    op_ok = 1'b0;
                    note_error($sformatf("command 0x%0h out of sequence", cmd.op));
                end
                if (op_ok) begin
                    check_value("cmd.bank", 32'(cmd.bank), 32'(r.bank));
                    check_value("cmd.row", 32'(cmd.row), 32'(r.row));
                    check_value("cmd.col", 32'(cmd.col), 32'(r.col));
                end
            end
            en = r.write ? wr_en : rd_en;
            if (en) begin
                if (en_first < 0) begin
                    en_first = k;
                end
                en_last = k;
                en_count++;
            end
            if (r.write ? rd_en : wr_en) begin
                wrong_en++;
            end
            if (done) begin
                done_count++;
                t_done = k;
            end
            if (t_pre >= 0 && k == t_pre + int'(dram_timing_pkg::T_RP) + 1) begin
                finished = 1'b1;
                if (check_ready) begin
                    check_value("ready", 32'(ready), 32'(1'b1));
                end
            end else if (ready) begin
                ready_busy++;
            end
        end

        if (!finished) begin
            note_error("access never went through precharge back to idle");
        end else begin
            check_value("act_after_strobe", t_act, 1);
            check_value("cas_after_act", t_cas - t_act, int'(dram_timing_pkg::T_RCD) + 1);
            check_value("data_start_after_cas", en_first - t_cas, lat + 1);
            check_value("data_cycles", en_count, int'(dram_timing_pkg::T_BURST));
            check_value("data_end_after_cas", en_last - t_cas,
                        lat + int'(dram_timing_pkg::T_BURST));
            check_value("done_pulses", done_count, 1);
            check_value("done_after_cas", t_done - t_cas,
                        lat + int'(dram_timing_pkg::T_BURST));
            check_value("pre_after_done", t_pre - t_done, 1);
            check_value("wrong_strobe_cycles", wrong_en, 0);
            check_value("ready_high_while_busy", ready_busy, 0);
            pre_cycle = start + t_pre;
        end
    endtask

    // REF cycle plus tRFC of refreshing with ready low
    task automatic wait_ref(output int t_ref);
        int n;
        int low_cycles;
        n = 0;
        t_ref = -1;
        while (t_ref < 0 && n < REF_PERIOD + 20) begin
            tick();
            n++;
            if (cmd.op == dram_cmd_pkg::REF) begin
                t_ref = cycle_no;
            end else if (cmd.op != dram_cmd_pkg::NOP) begin
                note_error("command other than REF issued while the host was idle");
            end
        end
        if (t_ref < 0) begin
            note_error("no REF command within a refresh period");
        end else begin
            low_cycles = 0;
            while (!ready && low_cycles < 2 * int'(dram_timing_pkg::T_RFC)) begin
                low_cycles++;
                tick();
            end
            check_value("ready_low_cycles", low_cycles, int'(dram_timing_pkg::T_RFC) + 1);
        end
    endtask

    task automatic test_reset();
        for (int i = 0; i < 4; i++) begin
            tick();
            check_quiet_outputs();
        end
        nRST = 1'b1;
        tick();
        check_quiet_outputs();
    endtask

    task automatic test_read();
        dram_cmd_pkg::host_req_t r;
        int pre_cycle;
        r.write = 1'b0;
        r.bank = 2'd1;
        r.row = 12'h5a3;
        r.col = 8'hc4;
        run_access(r, 1'b1, pre_cycle);
    endtask

    task automatic test_write();
        dram_cmd_pkg::host_req_t r;
        int pre_cycle;
        r.write = 1'b1;
        r.bank = 2'd2;
        r.row = 12'h0f1;
        r.col = 8'h3b;
        run_access(r, 1'b1, pre_cycle);
    endtask

    task automatic test_random();
        dram_cmd_pkg::host_req_t r;
        int pre_cycle;
        for (int i = 0; i < 10; i++) begin
            random_request(r);
            run_access(r, 1'b0, pre_cycle);
        end
    endtask

    task automatic test_refresh();
        int t0;
        int t1;
        int t2;
        int t3;
        // first interval may still be short from refresh debt
        wait_ref(t0);
        wait_ref(t1);
        wait_ref(t2);
        wait_ref(t3);
        if (t2 - t1 < REF_PERIOD || t2 - t1 > REF_PERIOD + 3 ||
            t3 - t2 < REF_PERIOD || t3 - t2 > REF_PERIOD + 3) begin
            note_error($sformatf("idle refresh intervals %0d and %0d out of range",
                                 t2 - t1, t3 - t2));
        end
        idle_interval = t3 - t2;
        last_ref = t3;
    endtask

    task automatic test_refresh_debt();
        dram_cmd_pkg::host_req_t r;
        int pre_cycle;
        int t_late;
        int t_next;
        int delay;
        int diff;
        // strobe a few cycles before rf_req rises so the access holds it off
        while (cycle_no < last_ref + idle_interval - 6) begin
            tick();
        end
        r.write = 1'b0;
        r.bank = 2'd3;
        r.row = 12'h2c7;
        r.col = 8'h19;
        run_access(r, 1'b0, pre_cycle);
        wait_ref(t_late);
        check_value("ref_after_pre", t_late - pre_cycle, int'(dram_timing_pkg::T_RP) + 2);
        delay = t_late - (last_ref + idle_interval);
        if (delay <= 0) begin
            note_error("refresh was not delayed by the access");
        end
        wait_ref(t_next);
        diff = (t_next - t_late) - (idle_interval - delay);
        if (diff < -3 || diff > 3) begin
            note_error($sformatf("refresh after debt came %0d cycles later, expected about %0d",
                                 t_next - t_late, idle_interval - delay));
        end
    endtask

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        req_valid = 1'b0;
        req = '0;
        error_count = 0;
        cycle_no = 0;
        idle_interval = REF_PERIOD;
        last_ref = 0;
        lfsr = 16'd99;

        test_reset();
        test_read();
        test_write();
        test_random();
        test_refresh();
        test_refresh_debt();

        $display("errors: %0d, cycles: %0d", error_count, cycle_no);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dram_ctrl.f ====
verilog/dram_timing_pkg.sv
verilog/dram_cmd_pkg.sv
verilog/flex_counter.sv
verilog/timing_signal.sv
verilog/command_fsm.sv
verilog/dram_ctrl.sv
bench/dram_ctrl_tb.sv

// ==== verilog/command_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module command_fsm (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       req_valid,
    input  dram_cmd_pkg::host_req_t    req,
    input  logic                       rf_req,
    input  dram_cmd_pkg::timing_done_t tim_done,
    output dram_cmd_pkg::cmd_state_t   state,
    output dram_cmd_pkg::dram_cmd_t    cmd,
    output logic                       ready,
    output logic                       done
);

    dram_cmd_pkg::cmd_state_t next_state;
    dram_cmd_pkg::host_req_t  req_q;
    logic                     accept;

    // a request is taken only from IDLE with no refresh pending
    assign accept = (state == dram_cmd_pkg::IDLE) && req_valid && !rf_req;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= dram_cmd_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // address held for ACT, RD/WR and PRE of the access
    always_ff @(posedge CLK) begin
        if (accept) begin
            req_q <= req;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dram_cmd_pkg::IDLE: begin
                if (rf_req) begin
                    next_state = dram_cmd_pkg::REFRESH;
                end else if (req_valid) begin
                    next_state = dram_cmd_pkg::ACTIVATE;
                end
            end
            dram_cmd_pkg::ACTIVATE:   next_state = dram_cmd_pkg::ACTIVATING;
            dram_cmd_pkg::ACTIVATING: begin
                if (tim_done.act_done) begin
                    next_state = req_q.write ? dram_cmd_pkg::WRITE : dram_cmd_pkg::READ;
                end
            end
            dram_cmd_pkg::READ:       next_state = dram_cmd_pkg::READING;
            dram_cmd_pkg::READING: begin
                if (tim_done.rd_done) begin
                    next_state = dram_cmd_pkg::PRECHARGE;
                end
            end
            dram_cmd_pkg::WRITE:      next_state = dram_cmd_pkg::WRITING;
            dram_cmd_pkg::WRITING: begin
                if (tim_done.wr_done) begin
                    next_state = dram_cmd_pkg::PRECHARGE;
                end
            end
            dram_cmd_pkg::PRECHARGE:  next_state = dram_cmd_pkg::PRECHARGING;
            dram_cmd_pkg::PRECHARGING: begin
                if (tim_done.pre_done) begin
                    next_state = dram_cmd_pkg::IDLE;
                end
            end
            dram_cmd_pkg::REFRESH:    next_state = dram_cmd_pkg::REFRESHING;
            dram_cmd_pkg::REFRESHING: begin
                if (tim_done.ref_done) begin
                    next_state = dram_cmd_pkg::IDLE;
                end
            end
            default:                  next_state = dram_cmd_pkg::IDLE;
        endcase
    end

    // one op per command state, address only on access commands
    always_comb begin
        cmd = '0;
        cmd.op = dram_cmd_pkg::NOP;
        case (state)
            dram_cmd_pkg::ACTIVATE:  cmd.op = dram_cmd_pkg::ACT;
            dram_cmd_pkg::READ:      cmd.op = dram_cmd_pkg::RD;
            dram_cmd_pkg::WRITE:     cmd.op = dram_cmd_pkg::WR;
            dram_cmd_pkg::PRECHARGE: cmd.op = dram_cmd_pkg::PRE;
            dram_cmd_pkg::REFRESH:   cmd.op = dram_cmd_pkg::REF;
            default:                 cmd.op = dram_cmd_pkg::NOP;
        endcase
        if ((cmd.op != dram_cmd_pkg::NOP) && (cmd.op != dram_cmd_pkg::REF)) begin
            cmd.bank = req_q.bank;
            cmd.row = req_q.row;
            cmd.col = req_q.col;
        end
    end

    // low while a refresh is pending, so no strobe is lost
    assign ready = (state == dram_cmd_pkg::IDLE) && !rf_req;

    // last data cycle of the access
    assign done = ((state == dram_cmd_pkg::READING) && tim_done.rd_done) ||
                  ((state == dram_cmd_pkg::WRITING) && tim_done.wr_done);

endmodule

`default_nettype wire

// ==== verilog/dram_cmd_pkg.sv ====
`default_nettype none

// controller states, DRAM commands and the structs passed between blocks
package dram_cmd_pkg;

    // address field widths
    localparam int unsigned BANK_W = 2;
    localparam int unsigned ROW_W = 12;
    localparam int unsigned COL_W = 8;

    // closed-page sequence, each command state followed by its wait state
    typedef enum logic [3:0] {
        IDLE        = 4'd0,
        ACTIVATE    = 4'd1,
        ACTIVATING  = 4'd2,
        READ        = 4'd3,
        READING     = 4'd4,
        WRITE       = 4'd5,
        WRITING     = 4'd6,
        PRECHARGE   = 4'd7,
        PRECHARGING = 4'd8,
        REFRESH     = 4'd9,
        REFRESHING  = 4'd10
    } cmd_state_t;

    // command on the DRAM bus
    typedef enum logic [2:0] {
        NOP = 3'd0,
        ACT = 3'd1,
        RD  = 3'd2,
        WR  = 3'd3,
        PRE = 3'd4,
        REF = 3'd5
    } dram_op_t;

    // host request, write set for a write access
    typedef struct packed {
        logic              write;
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
    } host_req_t;

    typedef struct packed {
        dram_op_t          op;
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
    } dram_cmd_t;

    // end of each wait state
    typedef struct packed {
        logic act_done;
        logic rd_done;
        logic wr_done;
        logic pre_done;
        logic ref_done;
    } timing_done_t;

endpackage

`default_nettype wire

// ==== verilog/dram_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module dram_ctrl (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    req_valid,
    input  dram_cmd_pkg::host_req_t req,
    output logic                    ready,
    output logic                    done,
    output dram_cmd_pkg::dram_cmd_t cmd,
    output logic                    rd_en,
    output logic                    wr_en
);

    dram_cmd_pkg::cmd_state_t   state;
    dram_cmd_pkg::timing_done_t tim_done;
    logic                       rf_req;

    command_fsm fsm (
        .CLK       (CLK),
        .nRST      (nRST),
        .req_valid (req_valid),
        .req       (req),
        .rf_req    (rf_req),
        .tim_done  (tim_done),
        .state     (state),
        .cmd       (cmd),
        .ready     (ready),
        .done      (done)
    );

    // delays, data strobes and refresh scheduling
    timing_signal timing (
        .CLK      (CLK),
        .nRST     (nRST),
        .state    (state),
        .tim_done (tim_done),
        .rf_req   (rf_req),
        .rd_en    (rd_en),
        .wr_en    (wr_en)
    );

endmodule

`default_nettype wire

// ==== verilog/dram_timing_pkg.sv ====
`default_nettype none

// timing constants for the DRAM controller, in clock cycles
package dram_timing_pkg;

    // width of the command delay and refresh interval counters
    localparam int unsigned CNT_W = 10;

    // activate to read or write
    localparam logic [CNT_W-1:0] T_RCD = CNT_W'(4);

    // additive latency, zero when AL is not programmed
    localparam logic [CNT_W-1:0] T_AL = CNT_W'(0);

    // read command to first data
    localparam logic [CNT_W-1:0] T_RL = CNT_W'(5);

    // write command to first data
    localparam logic [CNT_W-1:0] T_WL = CNT_W'(4);

    // data burst length on the bus
    localparam logic [CNT_W-1:0] T_BURST = CNT_W'(4);

    // precharge to next activate
    localparam logic [CNT_W-1:0] T_RP = CNT_W'(4);

    // refresh cycle time
    localparam logic [CNT_W-1:0] T_RFC = CNT_W'(20);

    // average refresh interval
    // kept short so that refresh shows up early in simulation
    localparam logic [CNT_W-1:0] T_REFI = CNT_W'(200);

endpackage

`default_nettype wire

// ==== verilog/flex_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module flex_counter (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic                             enable,
    input  logic [dram_timing_pkg::CNT_W-1:0] count_load,
    output logic [dram_timing_pkg::CNT_W-1:0] count,
    output logic                             count_done
);

    logic [dram_timing_pkg::CNT_W-1:0] next_count;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else begin
            count <= next_count;
        end
    end

    // load wins over the running count
    always_comb begin
        next_count = count;
        if (enable) begin
            next_count = count_load;
        end else if (count != '0) begin
            next_count = count - 1'b1;
        end
    end

    // last cycle of the loaded delay
    assign count_done = (count == dram_timing_pkg::CNT_W'(1));

endmodule

`default_nettype wire

// ==== verilog/timing_signal.sv ====
`timescale 1ns/1ns
`default_nettype none

module timing_signal (
    input  logic                       CLK,
    input  logic                       nRST,
    input  dram_cmd_pkg::cmd_state_t   state,
    output dram_cmd_pkg::timing_done_t tim_done,
    output logic                       rf_req,
    output logic                       rd_en,
    output logic                       wr_en
);

    logic [dram_timing_pkg::CNT_W-1:0] time_load;
    logic [dram_timing_pkg::CNT_W-1:0] time_count;
    logic                              time_counter_en;
    logic                              time_count_done;

    logic [dram_timing_pkg::CNT_W-1:0] refresh_count;
    logic [dram_timing_pkg::CNT_W-1:0] next_refresh_count;
    logic [dram_timing_pkg::CNT_W-1:0] refresh_limit;
    logic [dram_timing_pkg::CNT_W-1:0] next_refresh_limit;
    logic                              in_refresh;

    // command states load the delay, wait states watch for its end
    always_comb begin
        tim_done = '0;
        time_counter_en = 1'b0;
        time_load = '0;
        rd_en = 1'b0;
        wr_en = 1'b0;

        case (state)
            dram_cmd_pkg::ACTIVATE: begin
                time_counter_en = 1'b1;
                time_load = dram_timing_pkg::T_RCD - dram_timing_pkg::T_AL;
            end
            dram_cmd_pkg::ACTIVATING: begin
                tim_done.act_done = time_count_done;
            end
            dram_cmd_pkg::READ: begin
                time_counter_en = 1'b1;
                time_load = dram_timing_pkg::T_RL + dram_timing_pkg::T_BURST;
            end
            dram_cmd_pkg::READING: begin
                // data occupies the last T_BURST cycles, done cycle included
                rd_en = (time_count <= dram_timing_pkg::T_BURST);
                tim_done.rd_done = time_count_done;
            end
            dram_cmd_pkg::WRITE: begin
                time_counter_en = 1'b1;
                time_load = dram_timing_pkg::T_WL + dram_timing_pkg::T_BURST;
            end
            dram_cmd_pkg::WRITING: begin
                wr_en = (time_count <= dram_timing_pkg::T_BURST);
                tim_done.wr_done = time_count_done;
            end
            dram_cmd_pkg::PRECHARGE: begin
                time_counter_en = 1'b1;
                time_load = dram_timing_pkg::T_RP;
            end
            dram_cmd_pkg::PRECHARGING: begin
                tim_done.pre_done = time_count_done;
            end
            dram_cmd_pkg::REFRESH: begin
                time_counter_en = 1'b1;
                time_load = dram_timing_pkg::T_RFC;
            end
            dram_cmd_pkg::REFRESHING: begin
                tim_done.ref_done = time_count_done;
            end
            default: begin
                time_counter_en = 1'b0;
            end
        endcase
    end

    flex_counter time_counter (
        .CLK        (CLK),
        .nRST       (nRST),
        .enable     (time_counter_en),
        .count_load (time_load),
        .count      (time_count),
        .count_done (time_count_done)
    );

    assign in_refresh = (state == dram_cmd_pkg::REFRESH) ||
                        (state == dram_cmd_pkg::REFRESHING);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            refresh_count <= '0;
            refresh_limit <= dram_timing_pkg::T_REFI;
        end else begin
            refresh_count <= next_refresh_count;
            refresh_limit <= next_refresh_limit;
        end
    end

    // refresh interval with debt
    // a late refresh shortens the next interval by the overshoot
    always_comb begin
        next_refresh_limit = refresh_limit;
        next_refresh_count = refresh_count + 1'b1;

        if (in_refresh) begin
            next_refresh_count = '0;
            // early refresh pays off the debt, judged in the REF cycle
            if ((state == dram_cmd_pkg::REFRESH) &&
                (refresh_count < dram_timing_pkg::T_REFI)) begin
                next_refresh_limit = dram_timing_pkg::T_REFI;
            end
        end else if (refresh_count > dram_timing_pkg::T_REFI) begin
            next_refresh_limit = dram_timing_pkg::T_REFI -
                                 (refresh_count - dram_timing_pkg::T_REFI);
        end
    end

    // held until the FSM reaches REFRESH
    assign rf_req = (refresh_count >= refresh_limit) && (state != dram_cmd_pkg::REFRESH);

endmodule

`default_nettype wire
